/* hdl/additive_synth_defines.svh */
`ifndef ADDITIVE_SYNTH_DEFINES_SVH
`define ADDITIVE_SYNTH_DEFINES_SVH

// Sine table geometry
`define LUT_DEPTH     2048
`define LUT_ADDR_W    11

// Phase accumulators and frequency words share this width
`define PHASE_W       16

`define MAX_HARMONICS 16
`define FREQ_LIMIT    20000   // A step above this sets the too-high flag

// Wide enough for sixteen full-scale harmonics summed
`define MIX_W         21

// Register byte addresses on the AXI4-Lite port
`define REG_CTRL      5'h00
`define REG_FREQ      5'h04
`define REG_OFFSET    5'h08
`define REG_HARM      5'h0C
`define REG_STATUS    5'h10
`define REG_COUNT     5'h14

`endif

/* hdl/additive_synth_pkg.sv */
`include "additive_synth_defines.svh"

package additive_synth_pkg;

	// Configuration as seen by the mixer
	typedef struct packed {
		logic                enable;
		logic [`PHASE_W-1:0] freq;
		logic [`PHASE_W-1:0] offset;
		logic [4:0]          harm_count;   // Always 1 to 16
	} synth_cfg_t;

	typedef struct packed {
		logic [3:0]          index;
		logic [`PHASE_W-1:0] step;         // Accumulated frequency of this harmonic
		logic                first;        // Ignore the stored phase
	} harm_req_t;

	typedef struct packed {
		logic signed [15:0] sample;
		logic               too_high;
	} harm_rsp_t;

	typedef enum logic [4:0] {
		OP_CTRL   = `REG_CTRL,
		OP_FREQ   = `REG_FREQ,
		OP_OFFSET = `REG_OFFSET,
		OP_HARM   = `REG_HARM,
		OP_STATUS = `REG_STATUS,
		OP_COUNT  = `REG_COUNT
	} reg_op_e;

	typedef enum logic [1:0] {SP_IDLE, SP_ADD, SP_ROM, SP_RESP} sp_state_e;

	typedef enum logic [1:0] {MIX_IDLE, MIX_REQ, MIX_WAIT, MIX_PRESENT} mix_state_e;

endpackage

/* hdl/phase_ram.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

// One phase word per harmonic, read and written from the same address port
module phase_ram #(
	parameter int DEPTH = `MAX_HARMONICS,
	parameter int WIDTH = `PHASE_W
) (
	input  logic                     i_Clock,
	input  logic                     i_write,
	input  logic [$clog2(DEPTH)-1:0] i_addr,
	input  logic [WIDTH-1:0]         i_data,
	output logic [WIDTH-1:0]         o_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge i_Clock) begin
		if (i_write) begin
			mem[i_addr] <= i_data;
		end
		o_data <= mem[i_addr];   // Read returns the old word on a write cycle
	end

endmodule

/* hdl/sine_rom.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

// Full-cycle sine table, one entry per 32 phase counts
module sine_rom (
	input  logic                   i_Clock,
	input  logic [`LUT_ADDR_W-1:0] i_addr,
	output logic signed [15:0]     o_data
);

	localparam real TWO_PI    = 6.283185307179586;
	localparam real AMPLITUDE = 32767.0;

	logic signed [15:0] sine_table [`LUT_DEPTH];

	// The int cast rounds to the nearest integer
	initial begin
		for (int n = 0; n < `LUT_DEPTH; n++) begin
			sine_table[n] = 16'(int'(AMPLITUDE * $sin(TWO_PI * real'(n) / real'(`LUT_DEPTH))));
		end
	end

	always_ff @(posedge i_Clock) begin
		o_data <= sine_table[i_addr];
	end

endmodule

/* hdl/sample_position.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

module sample_position
	import additive_synth_pkg::*;
(
	input  logic      i_Clock,
	input  logic      i_reset,
	input  logic      i_req_valid,
	input  harm_req_t i_req,
	output logic      o_rsp_valid,
	output harm_rsp_t o_rsp
);

	sp_state_e           state;
	harm_req_t           req_q;
	logic [3:0]          ram_addr;
	logic                ram_write;
	logic [`PHASE_W-1:0] ram_rdata;
	logic [`PHASE_W-1:0] base_phase;
	logic [`PHASE_W-1:0] new_phase;
	logic [`PHASE_W-1:0] phase_q;
	logic signed [15:0]  rom_data;
	logic                too_high_q;

	// The RAM read starts in the accepting cycle, so idle addresses straight from the request
	assign ram_addr = (state == SP_IDLE) ? i_req.index : req_q.index;

	assign base_phase = req_q.first ? '0 : ram_rdata;   // First frame restarts every harmonic at zero
	assign new_phase  = base_phase + req_q.step;
	assign ram_write  = (state == SP_ADD);

	phase_ram phase_ram_inst (
		.i_Clock (i_Clock),
		.i_write (ram_write),
		.i_addr  (ram_addr),
		.i_data  (new_phase),
		.o_data  (ram_rdata)
	);

	// 2048 entries over 65536 phase counts, so the top bits index the table
	sine_rom sine_rom_inst (
		.i_Clock (i_Clock),
		.i_addr  (phase_q[`PHASE_W-1 -: `LUT_ADDR_W]),
		.o_data  (rom_data)
	);

	always_ff @(posedge i_Clock) begin
		if (i_reset) begin
			state       <= SP_IDLE;
			o_rsp_valid <= 1'b0;
			too_high_q  <= 1'b0;
		end else begin
			case (state)
				SP_IDLE: begin
					if (i_req_valid) begin
						state <= SP_ADD;
					end
				end
				SP_ADD: begin
					state <= SP_ROM;   // Phase written back this cycle
				end
				SP_ROM: begin
					o_rsp_valid <= 1'b1;
					too_high_q  <= (req_q.step > `FREQ_LIMIT);
					state       <= SP_RESP;
				end
				SP_RESP: begin
					o_rsp_valid <= 1'b0;
					state       <= SP_IDLE;
				end
				default: state <= SP_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_Clock) begin
		if (state == SP_IDLE && i_req_valid) begin
			req_q <= i_req;
		end
		if (state == SP_ADD) begin
			phase_q <= new_phase;
		end
	end

	assign o_rsp.sample   = rom_data;
	assign o_rsp.too_high = too_high_q;

	// The mixer must wait for the response before raising another request
	assert property (@(posedge i_Clock) disable iff (i_reset)
		$rose(i_req_valid) |-> state == SP_IDLE);

endmodule

/* hdl/harmonic_mixer.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

module harmonic_mixer
	import additive_synth_pkg::*;
(
	input  logic                    i_Clock,
	input  logic                    i_reset,
	input  synth_cfg_t              i_cfg,
	input  logic                    i_rsp_valid,
	input  harm_rsp_t               i_rsp,
	input  logic                    i_sample_ready,
	output logic                    o_req_valid,
	output harm_req_t               o_req,
	output logic                    o_sample_valid,
	output logic signed [`MIX_W-1:0] o_sample_data,
	output logic                    o_frame_done,
	output logic                    o_too_high
);

	mix_state_e               state;
	synth_cfg_t               cfg_q;
	logic [3:0]               idx_q;
	logic [`PHASE_W-1:0]      step_q;
	logic signed [`MIX_W-1:0] acc_q;
	logic signed [`MIX_W-1:0] rsp_ext;
	logic                     too_high_acc;
	logic                     first_q;
	logic                     first_pending;
	logic                     enable_d;
	logic                     enable_rise;
	logic                     frame_start;
	logic                     last_harm;

	assign enable_rise = i_cfg.enable & ~enable_d;
	assign frame_start = (state == MIX_IDLE) && i_cfg.enable;
	assign last_harm   = ({1'b0, idx_q} + 5'd1) == cfg_q.harm_count;
	assign rsp_ext     = {{(`MIX_W-16){i_rsp.sample[15]}}, i_rsp.sample};

	always_ff @(posedge i_Clock) begin
		if (i_reset) begin
			state          <= MIX_IDLE;
			o_req_valid    <= 1'b0;
			o_sample_valid <= 1'b0;
			o_frame_done   <= 1'b0;
			o_too_high     <= 1'b0;
			enable_d       <= 1'b0;
			first_pending  <= 1'b0;
		end else begin
			enable_d     <= i_cfg.enable;
			o_frame_done <= 1'b0;
			o_too_high   <= 1'b0;
			if (frame_start)
				first_pending <= 1'b0;
			else if (enable_rise)
				first_pending <= 1'b1;

			case (state)
				MIX_IDLE: if (frame_start) state <= MIX_REQ;
				MIX_REQ: begin
					o_req_valid <= 1'b1;   // Low for this one cycle between harmonics
					state       <= MIX_WAIT;
				end
				MIX_WAIT: begin
					if (i_rsp_valid) begin
						o_req_valid <= 1'b0;
						if (last_harm) begin
							o_sample_valid <= 1'b1;
							o_too_high     <= too_high_acc | i_rsp.too_high;
							state          <= MIX_PRESENT;
						end else begin
							state <= MIX_REQ;
						end
					end
				end
				MIX_PRESENT: begin
					if (i_sample_ready) begin
						o_sample_valid <= 1'b0;
						o_frame_done   <= 1'b1;
						state          <= MIX_IDLE;
					end
				end
				default: state <= MIX_IDLE;
			endcase
		end
	end

	// Per-frame working values
	always_ff @(posedge i_Clock) begin
		if (frame_start) begin
			cfg_q        <= i_cfg;
			step_q       <= i_cfg.freq;   // Harmonic 1 steps by the fundamental
			idx_q        <= '0;
			acc_q        <= '0;
			too_high_acc <= 1'b0;
			first_q      <= first_pending | enable_rise;
		end else if (state == MIX_WAIT && i_rsp_valid) begin
			acc_q        <= acc_q + rsp_ext;
			too_high_acc <= too_high_acc | i_rsp.too_high;
			idx_q        <= idx_q + 4'd1;
			step_q       <= step_q + cfg_q.freq + cfg_q.offset;
			if (last_harm)
				o_sample_data <= acc_q + rsp_ext;
		end
	end

	assign o_req.index = idx_q;
	assign o_req.step  = step_q;
	assign o_req.first = first_q;

	assert property (@(posedge i_Clock) disable iff (i_reset)
		o_sample_valid && !i_sample_ready |=> o_sample_valid && $stable(o_sample_data));

endmodule

/* hdl/synth_regs_axil.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

module synth_regs_axil
	import additive_synth_pkg::*;
(
	input  logic        i_Clock,
	input  logic        i_reset,
	input  logic        i_awvalid,
	input  logic [4:0]  i_awaddr,
	output logic        o_awready,
	input  logic        i_wvalid,
	input  logic [31:0] i_wdata,
	output logic        o_wready,
	output logic        o_bvalid,
	output logic [1:0]  o_bresp,
	input  logic        i_bready,
	input  logic        i_arvalid,
	input  logic [4:0]  i_araddr,
	output logic        o_arready,
	output logic        o_rvalid,
	output logic [31:0] o_rdata,
	output logic [1:0]  o_rresp,
	input  logic        i_rready,
	input  logic        i_frame_done,
	input  logic        i_too_high,
	output synth_cfg_t  o_cfg
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        wr_ready_q;
	logic        ar_ready_q;
	logic        aw_accept;
	logic        ar_accept;
	reg_op_e     wr_op;
	reg_op_e     rd_op;
	logic [4:0]  harm_clamped;
	logic [31:0] rd_data;
	logic        rd_err;
	logic        too_high_sticky;
	logic [31:0] frame_count;

	assign o_awready = wr_ready_q;   // AW and W are taken in the same cycle
	assign o_wready  = wr_ready_q;
	assign o_arready = ar_ready_q;
	assign aw_accept = wr_ready_q & i_awvalid & i_wvalid;
	assign ar_accept = ar_ready_q & i_arvalid;
	assign wr_op     = reg_op_e'(i_awaddr);
	assign rd_op     = reg_op_e'(i_araddr);

	always_comb begin
		if (i_wdata == 32'd0)
			harm_clamped = 5'd1;
		else if (i_wdata > `MAX_HARMONICS)
			harm_clamped = 5'(`MAX_HARMONICS);
		else
			harm_clamped = i_wdata[4:0];
	end

	always_comb begin
		rd_data = 32'd0;
		rd_err  = 1'b0;
		case (rd_op)
			OP_CTRL:   rd_data = {31'd0, o_cfg.enable};
			OP_FREQ:   rd_data = {16'd0, o_cfg.freq};
			OP_OFFSET: rd_data = {16'd0, o_cfg.offset};
			OP_HARM:   rd_data = {27'd0, o_cfg.harm_count};
			OP_STATUS: rd_data = {31'd0, too_high_sticky};
			OP_COUNT:  rd_data = frame_count;
			default:   rd_err  = 1'b1;
		endcase
	end

	always_ff @(posedge i_Clock) begin
		if (i_reset) begin
			wr_ready_q       <= 1'b0;
			o_bvalid         <= 1'b0;
			o_bresp          <= RESP_OKAY;
			o_cfg            <= '0;
			o_cfg.harm_count <= 5'd1;
			too_high_sticky  <= 1'b0;
			frame_count      <= 32'd0;
		end else begin
			if (aw_accept) begin
				wr_ready_q <= 1'b0;
				o_bvalid   <= 1'b1;
				o_bresp    <= RESP_OKAY;
				case (wr_op)
					OP_CTRL:   o_cfg.enable     <= i_wdata[0];
					OP_FREQ:   o_cfg.freq       <= i_wdata[15:0];
					OP_OFFSET: o_cfg.offset     <= i_wdata[15:0];
					OP_HARM:   o_cfg.harm_count <= harm_clamped;
					OP_STATUS: if (i_wdata[0]) too_high_sticky <= 1'b0;   // Write one to clear
					OP_COUNT:  ;   // Read only, write is ignored
					default:   o_bresp <= RESP_SLVERR;
				endcase
			end else if (!o_bvalid && !wr_ready_q && i_awvalid && i_wvalid) begin
				wr_ready_q <= 1'b1;
			end
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			if (i_too_high)
				too_high_sticky <= 1'b1;   // A new event wins over a clear
			if (i_frame_done)
				frame_count <= frame_count + 32'd1;
		end
	end

	always_ff @(posedge i_Clock) begin
		if (i_reset) begin
			ar_ready_q <= 1'b0;
			o_rvalid   <= 1'b0;
			o_rresp    <= RESP_OKAY;
		end else begin
			if (ar_accept) begin
				ar_ready_q <= 1'b0;
				o_rvalid   <= 1'b1;
				o_rresp    <= rd_err ? RESP_SLVERR : RESP_OKAY;
			end else if (!o_rvalid && !ar_ready_q && i_arvalid) begin
				ar_ready_q <= 1'b1;
			end
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_Clock) begin
		if (ar_accept)
			o_rdata <= rd_data;
	end

	assert property (@(posedge i_Clock) disable iff (i_reset) $rose(o_bvalid) |-> $past(aw_accept));
	assert property (@(posedge i_Clock) disable iff (i_reset) $rose(o_rvalid) |-> $past(ar_accept));

endmodule

/* hdl/additive_synth_top.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

module additive_synth_top
	import additive_synth_pkg::*;
(
	input  logic                     i_Clock,
	input  logic                     i_reset,
	input  logic                     i_awvalid,
	input  logic [4:0]               i_awaddr,
	output logic                     o_awready,
	input  logic                     i_wvalid,
	input  logic [31:0]              i_wdata,
	output logic                     o_wready,
	output logic                     o_bvalid,
	output logic [1:0]               o_bresp,
	input  logic                     i_bready,
	input  logic                     i_arvalid,
	input  logic [4:0]               i_araddr,
	output logic                     o_arready,
	output logic                     o_rvalid,
	output logic [31:0]              o_rdata,
	output logic [1:0]               o_rresp,
	input  logic                     i_rready,
	output logic                     o_sample_valid,
	output logic signed [`MIX_W-1:0] o_sample_data,
	input  logic                     i_sample_ready
);

	synth_cfg_t cfg;
	harm_req_t  req;
	harm_rsp_t  rsp;
	logic       req_valid;
	logic       rsp_valid;
	logic       frame_done;
	logic       too_high;

	synth_regs_axil synth_regs_axil_inst (
		.i_Clock, .i_reset,
		.i_awvalid, .i_awaddr, .o_awready, .i_wvalid, .i_wdata, .o_wready,
		.o_bvalid, .o_bresp, .i_bready,
		.i_arvalid, .i_araddr, .o_arready, .o_rvalid, .o_rdata, .o_rresp, .i_rready,
		.i_frame_done (frame_done),
		.i_too_high   (too_high),
		.o_cfg        (cfg)
	);

	harmonic_mixer harmonic_mixer_inst (
		.i_Clock, .i_reset,
		.i_cfg          (cfg),
		.i_rsp_valid    (rsp_valid),
		.i_rsp          (rsp),
		.i_sample_ready,
		.o_req_valid    (req_valid),
		.o_req          (req),
		.o_sample_valid,
		.o_sample_data,
		.o_frame_done   (frame_done),
		.o_too_high     (too_high)
	);

	sample_position sample_position_inst (
		.i_Clock, .i_reset,
		.i_req_valid (req_valid),
		.i_req       (req),
		.o_rsp_valid (rsp_valid),
		.o_rsp       (rsp)
	);

endmodule

/* verif/additive_synth_tb.sv */
`timescale 1ns/1ps
`include "additive_synth_defines.svh"

module additive_synth_tb;

	localparam int          TIMEOUT_CYCLES = 1000;
	localparam int          DRAIN_CYCLES   = 100;   // Longer than a 16-harmonic frame of 81 cycles
	localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
	localparam real         TWO_PI         = 6.283185307179586;
	localparam int          QUARTER_WAVE [4] = '{32767, 0, -32767, 0};

	logic                     i_Clock;
	logic                     i_reset;
	logic                     i_awvalid;
	logic [4:0]               i_awaddr;
	logic                     o_awready;
	logic                     i_wvalid;
	logic [31:0]              i_wdata;
	logic                     o_wready;
	logic                     o_bvalid;
	logic [1:0]               o_bresp;
	logic                     i_bready;
	logic                     i_arvalid;
	logic [4:0]               i_araddr;
	logic                     o_arready;
	logic                     o_rvalid;
	logic [31:0]              o_rdata;
	logic [1:0]               o_rresp;
	logic                     i_rready;
	logic                     o_sample_valid;
	logic signed [`MIX_W-1:0] o_sample_data;
	logic                     i_sample_ready;

	int          accepted_count;   // Every sample taken off the stream since reset
	logic [31:0] lfsr_state;

	additive_synth_top additive_synth_top_inst (.*);

	always #20 i_Clock = ~i_Clock;

	task automatic check_value(input string what, input longint actual, input longint expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic report_hang(input string what);
		$display("Timeout: %s did not happen within %0d clock cycles", what, TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation hung");
	endtask

	// All bus tasks start and end on a falling edge
	task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int cycles;
		cycles    = 0;
		i_awaddr  = addr;
		i_awvalid = 1'b1;
		i_wdata   = data;
		i_wvalid  = 1'b1;
		i_bready  = 1'b1;
		@(negedge i_Clock);
		while (!(o_awready && o_wready)) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				report_hang("AXI write address and data acceptance");
			@(negedge i_Clock);
		end
		@(negedge i_Clock);   // Taken on the rising edge just passed
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		cycles    = 0;
		while (!o_bvalid) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				report_hang("AXI write response");
			@(negedge i_Clock);
		end
		resp = o_bresp;
		@(negedge i_Clock);
		i_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int cycles;
		cycles    = 0;
		i_araddr  = addr;
		i_arvalid = 1'b1;
		i_rready  = 1'b1;
		@(negedge i_Clock);
		while (!o_arready) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				report_hang("AXI read address acceptance");
			@(negedge i_Clock);
		end
		@(negedge i_Clock);
		i_arvalid = 1'b0;
		cycles    = 0;
		while (!o_rvalid) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				report_hang("AXI read data");
			@(negedge i_Clock);
		end
		data = o_rdata;
		resp = o_rresp;
		@(negedge i_Clock);
		i_rready = 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_value("write response", resp, 0);
	endtask

	task automatic read_expect(input logic [4:0] addr, input longint expected, input string what);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(addr, data, resp);
		check_value("read response", resp, 0);
		check_value(what, data, expected);
	endtask

	// Waits for a sample, holds ready low for the stall and then takes it
	task automatic get_sample(input int stall, output int value);
		int                       cycles;
		int                       i;
		logic signed [`MIX_W-1:0] held;
		cycles = 0;
		while (!o_sample_valid) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				report_hang("Output sample");
			@(negedge i_Clock);
		end
		held = o_sample_data;
		for (i = 0; i < stall; i++) begin
			@(negedge i_Clock);
			check_value("valid during stall", longint'(o_sample_valid), 1);
			check_value("data during stall", o_sample_data, held);
		end
		i_sample_ready = 1'b1;
		@(negedge i_Clock);
		i_sample_ready = 1'b0;
		value = held;
		accepted_count++;
	endtask

	// Turns the generator off and takes whatever frame was still in flight
	task automatic stop_and_drain();
		int i;
		write_reg(`REG_CTRL, 32'd0);
		i_sample_ready = 1'b1;
		for (i = 0; i < DRAIN_CYCLES; i++) begin
			if (o_sample_valid)
				accepted_count++;   // Ready is high, so the next rising edge takes it
			@(negedge i_Clock);
		end
		i_sample_ready = 1'b0;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		else
			return state >> 1;
	endfunction

	task automatic random_bits(input int count, output int value);
		int i;
		value = 0;
		for (i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	function automatic int rounded_sine(input logic [15:0] phase);
		real scaled;
		scaled = 32767.0 * $sin(TWO_PI * real'(phase[15:5]) / 2048.0);
		return $rtoi($floor(scaled + 0.5));
	endfunction

	// Sample k of the first run after enable, each harmonic starting from phase zero
	function automatic int expected_mix(input int k, input int freq, input int offset,
			input int harms);
		int          step;
		int          total;
		int          h;
		logic [15:0] phase;
		step  = freq;
		total = 0;
		for (h = 0; h < harms; h++) begin
			phase = 16'(k * step);
			total += rounded_sine(phase);
			step  = (step + freq + offset) & 32'hFFFF;
		end
		return total;
	endfunction

	task automatic access_registers();
		logic [31:0] data;
		logic [1:0]  resp;
		read_expect(`REG_CTRL, 0, "CTRL after reset");
		write_reg(`REG_FREQ, 32'h1234);
		read_expect(`REG_FREQ, 32'h1234, "FREQ");
		write_reg(`REG_OFFSET, 32'h0321);
		read_expect(`REG_OFFSET, 32'h0321, "OFFSET");
		write_reg(`REG_HARM, 32'd5);
		read_expect(`REG_HARM, 5, "HARM of 5");
		write_reg(`REG_HARM, 32'd0);
		read_expect(`REG_HARM, 1, "HARM of 0");   // Clamped up to one harmonic
		write_reg(`REG_HARM, 32'd20);
		read_expect(`REG_HARM, 16, "HARM of 20");
		read_expect(`REG_STATUS, 0, "STATUS after reset");
		read_expect(`REG_COUNT, 0, "COUNT after reset");
		axil_read(5'h18, data, resp);
		check_value("unmapped read response", resp, 2);
		axil_write(5'h1C, 32'd1, resp);
		check_value("unmapped write response", resp, 2);
	endtask

	task automatic play_quarter_steps();
		int value;
		int k;
		write_reg(`REG_FREQ, 32'd16384);
		write_reg(`REG_OFFSET, 32'd0);
		write_reg(`REG_HARM, 32'd1);
		write_reg(`REG_CTRL, 32'd1);
		for (k = 0; k < 4; k++) begin
			get_sample(0, value);
			check_value("single harmonic sample", value, QUARTER_WAVE[k]);
		end
	endtask

	// Harmonic 2 steps by half a cycle and lands on zero every time
	task automatic mix_two_harmonics();
		int value;
		int k;
		stop_and_drain();
		write_reg(`REG_HARM, 32'd2);
		write_reg(`REG_CTRL, 32'd1);
		for (k = 0; k < 4; k++) begin
			get_sample(0, value);
			check_value("two harmonic sample", value, QUARTER_WAVE[k]);
		end
	endtask

	task automatic flag_and_clear_too_high();
		int value;
		int k;
		read_expect(`REG_STATUS, 1, "STATUS with step 32768");
		stop_and_drain();
		write_reg(`REG_STATUS, 32'd1);
		write_reg(`REG_HARM, 32'd1);
		write_reg(`REG_FREQ, 32'd8192);
		read_expect(`REG_STATUS, 0, "STATUS after clear");
		write_reg(`REG_CTRL, 32'd1);
		for (k = 1; k <= 3; k++) begin
			get_sample(0, value);
			check_value("eighth step sample", value, expected_mix(k, 8192, 0, 1));
		end
		read_expect(`REG_STATUS, 0, "STATUS with step 8192");
	endtask

	task automatic stall_with_offset();
		int value;
		int stall;
		int k;
		stop_and_drain();
		write_reg(`REG_FREQ, 32'd4096);
		write_reg(`REG_OFFSET, 32'd4096);
		write_reg(`REG_HARM, 32'd2);
		write_reg(`REG_CTRL, 32'd1);
		for (k = 1; k <= 12; k++) begin
			random_bits(3, stall);
			get_sample(stall, value);
			check_value("stalled sample", value, expected_mix(k, 4096, 4096, 2));
		end
		stop_and_drain();
		read_expect(`REG_COUNT, accepted_count, "COUNT");
	endtask

	initial begin
		i_Clock        = 1'b0;
		i_reset        = 1'b1;
		i_awvalid      = 1'b0;
		i_awaddr       = '0;
		i_wvalid       = 1'b0;
		i_wdata        = '0;
		i_bready       = 1'b0;
		i_arvalid      = 1'b0;
		i_araddr       = '0;
		i_rready       = 1'b0;
		i_sample_ready = 1'b0;
		accepted_count = 0;
		lfsr_state     = 32'd65850;
		repeat (8) @(negedge i_Clock);
		i_reset = 1'b0;
		@(negedge i_Clock);
		check_value("valid after reset", longint'(o_sample_valid), 0);
		check_value("BVALID after reset", longint'(o_bvalid), 0);
		check_value("RVALID after reset", longint'(o_rvalid), 0);
		check_value("AWREADY after reset", longint'(o_awready), 0);
		check_value("WREADY after reset", longint'(o_wready), 0);
		check_value("ARREADY after reset", longint'(o_arready), 0);
		access_registers();
		play_quarter_steps();
		mix_two_harmonics();
		flag_and_clear_too_high();
		stall_with_offset();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/additive_synth_pkg.sv
hdl/phase_ram.sv
hdl/sine_rom.sv
hdl/sample_position.sv
hdl/harmonic_mixer.sv
hdl/synth_regs_axil.sv
hdl/additive_synth_top.sv
verif/additive_synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module additive_synth_tb \
	-f filelist.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
